// File: common/msp430CtrlPkg.sv
// package: microcode states, instruction views, step and trace records, register and bus constants.
package msp430CtrlPkg;

    // #########################################################################
    // microcode states, grouped by family.
    // #########################################################################
    typedef enum logic [5:0] {
        CAR_0,
        CAR_REG_REG,
        CAR_REG_IDX0, CAR_REG_IDX1, CAR_REG_IDX2, CAR_REG_IDX3,
        CAR_IND_REG0, CAR_IND_REG1,
        CAR_IND_IDX0, CAR_IND_IDX1, CAR_IND_IDX2, CAR_IND_IDX3, CAR_IND_IDX4,
        CAR_IDX_REG0, CAR_IDX_REG1, CAR_IDX_REG2,
        CAR_IDX_IDX0, CAR_IDX_IDX1, CAR_IDX_IDX2, CAR_IDX_IDX3, CAR_IDX_IDX4, CAR_IDX_IDX5,
        CAR_1OP_REG,
        CAR_1OP_IND0, CAR_1OP_IND1, CAR_1OP_IND2,
        CAR_1OP_IDX0, CAR_1OP_IDX1, CAR_1OP_IDX2, CAR_1OP_IDX3,
        CAR_PUSH_REG0, CAR_PUSH_REG1, CAR_PUSH_REG2,
        CAR_PUSH_IND0, CAR_PUSH_IND1, CAR_PUSH_IND2,
        CAR_PUSH_IDX0, CAR_PUSH_IDX1, CAR_PUSH_IDX2, CAR_PUSH_IDX3,
        CAR_CALL_REG0, CAR_CALL_REG1, CAR_CALL_REG2,
        CAR_CALL_IND0, CAR_CALL_IND1, CAR_CALL_IND2,
        CAR_CALL_IDX0, CAR_CALL_IDX1, CAR_CALL_IDX2, CAR_CALL_IDX3,
        CAR_RETI0, CAR_RETI1, CAR_RETI2, CAR_RETI3,
        CAR_INT0, CAR_INT1, CAR_INT2, CAR_INT3, CAR_INT4,
        CAR_JMP0,
        CAR_IDLE = 6'h3F            // no instruction in flight.
    } carState;

    // #########################################################################
    // instruction word, three decodings of the same 16 bits.
    // #########################################################################
    typedef struct packed {
        logic [3:0] opcode;
        logic [3:0] srcReg;
        logic       ad;
        logic       bw;
        logic [1:0] as;
        logic [3:0] dstReg;
    } fmt1Fields;

    typedef struct packed {
        logic [5:0] prefix;         // 000100 for single operand.
        logic [2:0] op3;
        logic       bw;
        logic [1:0] as;
        logic [3:0] regNum;
    } fmt2Fields;

    typedef struct packed {
        logic [2:0] prefix;         // 001 for jumps.
        logic [2:0] cond;
        logic [9:0] offset;
    } jmpFields;

    typedef union packed {
        fmt1Fields fmt1;
        fmt2Fields fmt2;
        jmpFields  jmp;
    } instrWord;

    localparam logic [5:0] Fmt2Prefix = 6'b000100;
    localparam logic [2:0] JmpPrefix  = 3'b001;
    localparam logic [2:0] Op3Push    = 3'b100;
    localparam logic [2:0] Op3Call    = 3'b101;
    localparam logic [2:0] Op3Reti    = 3'b110;

    // push r0, seen by the datapath during interrupt entry.
    localparam instrWord pushWord = 16'h1200;

    // register numbers.
    localparam logic [3:0] PC = 4'd0;
    localparam logic [3:0] SP = 4'd1;
    localparam logic [3:0] SR = 4'd2;

    // one microstep as driven to the datapath.
    typedef struct packed {
        carState     car;
        logic [11:0] controlWord;  // {PCO[1:0], MEM, EX, srcM, srcL, dstM, dstL, AddrM[1:0], AddrL, IdxM}.
        logic [3:0]  srcA;
        logic [3:0]  dstA;
        logic [1:0]  as;
        logic        ad;
        logic        format;       // 1 for single operand.
    } ctrlStep;

    typedef struct packed {
        logic [1:0] pad;
        ctrlStep    step;
    } traceEntry;

    typedef struct packed {
        logic [15:0] reserved;
        logic [7:0]  count;
        logic [5:0]  spare;
        logic        full;
        logic        busy;
    } statusWord;

    // apb register map.
    localparam int unsigned AddrIr     = 'h0;
    localparam int unsigned AddrStatus = 'h4;
    localparam int unsigned AddrTrace  = 'h8;

endpackage

// File: controller/carSequencer.sv
// carSequencer: instruction decode to microcode entry state, CAR stepping, interrupt entry.
module carSequencer (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   start,
    input  msp430CtrlPkg::instrWord irWord,
    input  logic                   intReq,
    input  logic                   full,
    output msp430CtrlPkg::carState car,
    output msp430CtrlPkg::instrWord ir,
    output logic                   stepValid,
    output logic                   busy
);
    import msp430CtrlPkg::*;

    // family entry by addressing mode: register, indexed, indirect.
    function automatic carState pickMode(logic [1:0] as, carState r, carState x, carState i);
        if (as == 2'b00) return r;
        if (as == 2'b01) return x;
        return i;
    endfunction

    function automatic carState entryCar(instrWord w);
        carState c;
        if (w.jmp.prefix == JmpPrefix) begin
            c = CAR_JMP0;
        end else if (w.fmt2.prefix == Fmt2Prefix) begin
            case (w.fmt2.op3)
                Op3Push: c = pickMode(w.fmt2.as, CAR_PUSH_REG0, CAR_PUSH_IDX0, CAR_PUSH_IND0);
                Op3Call: c = pickMode(w.fmt2.as, CAR_CALL_REG0, CAR_CALL_IDX0, CAR_CALL_IND0);
                Op3Reti: c = CAR_RETI0;
                default: c = pickMode(w.fmt2.as, CAR_1OP_REG, CAR_1OP_IDX0, CAR_1OP_IND0);
            endcase
        end else begin
            // two operands, Ad picks the destination half.
            c = pickMode(w.fmt1.as,
                         w.fmt1.ad ? CAR_REG_IDX0 : CAR_REG_REG,
                         w.fmt1.ad ? CAR_IDX_IDX0 : CAR_IDX_REG0,
                         w.fmt1.ad ? CAR_IND_IDX0 : CAR_IND_REG0);
        end
        return c;
    endfunction

    // states of a family are contiguous, so only the tails need listing.
    function automatic carState nextCar(carState c);
        case (c)
            CAR_0, CAR_REG_REG, CAR_REG_IDX3, CAR_IND_REG1, CAR_IND_IDX4,
            CAR_IDX_REG2, CAR_IDX_IDX5, CAR_1OP_REG, CAR_1OP_IND2, CAR_1OP_IDX3,
            CAR_PUSH_REG2, CAR_PUSH_IND2, CAR_PUSH_IDX3,
            CAR_CALL_REG2, CAR_CALL_IND2, CAR_CALL_IDX3,
            CAR_RETI3, CAR_INT4, CAR_JMP0:
                return CAR_IDLE;
            default:
                return carState'(c + 6'd1);
        endcase
    endfunction

    // #########################################################################
    // control address register.
    // #########################################################################
    always_ff @(posedge clk) begin
        if (!rstN) begin
            car <= CAR_IDLE;
        end else if (car == CAR_IDLE) begin
            if (start) car <= entryCar(irWord);      // a host write wins.
            else if (intReq) car <= CAR_INT0;
        end else if (!full) begin
            car <= nextCar(car);
        end
    end

    always_ff @(posedge clk) begin
        if (start && car == CAR_IDLE) ir <= irWord;
    end

    assign busy      = (car != CAR_IDLE);
    assign stepValid = busy && !full;              // stalled steps are not recorded.

    // leaving idle needs a cause.
    idleNeedsCause: assert property (@(posedge clk) disable iff (!rstN)
        (car == CAR_IDLE && !start && !intReq) |=> car == CAR_IDLE);

    // CAR moves exactly on recorded steps, so a full trace freezes it.
    holdWhileFull: assert property (@(posedge clk) disable iff (!rstN)
        (car != CAR_IDLE) |=> ((car != $past(car)) == $past(stepValid)));

endmodule

// File: controller/controlUnit.sv
// controlUnit: CAR state to control word, operand fields and interrupt acknowledge.
module controlUnit (
    input  msp430CtrlPkg::carState  car,
    input  msp430CtrlPkg::instrWord ir,
    output msp430CtrlPkg::ctrlStep  step,
    output logic                    intAck
);
    import msp430CtrlPkg::*;

    instrWord iw;       // word seen by the datapath.

    always_comb begin
        iw = ir;
        if (car == CAR_INT1 || car == CAR_INT3) iw = pushWord;
    end

    assign intAck = (car == CAR_INT4);

    always_comb begin
        // fields straight from the instruction.
        step.car    = car;
        step.srcA   = iw.fmt1.srcReg;
        step.dstA   = iw.fmt1.dstReg;
        step.as     = iw.fmt1.as;
        step.ad     = iw.fmt1.ad;
        step.format = (iw.fmt2.prefix == Fmt2Prefix);

        case (car)
            CAR_0:         step.controlWord = 12'h400;
            CAR_REG_REG:   step.controlWord = 12'h500;
            CAR_REG_IDX0:  step.controlWord = 12'h823;
            CAR_REG_IDX1:  step.controlWord = 12'h230;
            CAR_REG_IDX2:  step.controlWord = 12'h320;
            CAR_REG_IDX3:  step.controlWord = 12'h400;
            CAR_IND_REG0:  step.controlWord = 12'h2C8;
            CAR_IND_REG1:  step.controlWord = 12'h580;
            CAR_IND_IDX0:  step.controlWord = 12'h2E8;
            CAR_IND_IDX1:  step.controlWord = 12'h8A3;
            CAR_IND_IDX2:  step.controlWord = 12'h2B0;
            CAR_IND_IDX3:  step.controlWord = 12'h3A0;
            CAR_IND_IDX4:  step.controlWord = 12'h400;
            CAR_IDX_REG0:  step.controlWord = 12'h882;
            CAR_IDX_REG1:  step.controlWord = 12'h2C0;
            CAR_IDX_REG2:  step.controlWord = 12'h580;
            CAR_IDX_IDX0:  step.controlWord = 12'h8A2;
            CAR_IDX_IDX1:  step.controlWord = 12'h2E0;
            CAR_IDX_IDX2:  step.controlWord = 12'h8A3;
            CAR_IDX_IDX3:  step.controlWord = 12'h2B0;
            CAR_IDX_IDX4:  step.controlWord = 12'h3A0;
            CAR_IDX_IDX5:  step.controlWord = 12'h400;
            CAR_1OP_REG:   step.controlWord = 12'h500;
            CAR_1OP_IND0:  step.controlWord = 12'h23E;
            CAR_1OP_IND1:  step.controlWord = 12'h320;
            CAR_1OP_IND2:  step.controlWord = 12'h420;
            CAR_1OP_IDX0:  step.controlWord = 12'h823;
            CAR_1OP_IDX1:  step.controlWord = 12'h230;
            CAR_1OP_IDX2:  step.controlWord = 12'h320;
            CAR_1OP_IDX3:  step.controlWord = 12'h400;
            CAR_PUSH_REG0: step.controlWord = 12'h010;
            CAR_PUSH_REG1: step.controlWord = 12'h324;
            CAR_PUSH_REG2: step.controlWord = 12'h400;
            CAR_PUSH_IND0: step.controlWord = 12'h23C;
            CAR_PUSH_IND1: step.controlWord = 12'h324;
            CAR_PUSH_IND2: step.controlWord = 12'h400;
            CAR_PUSH_IDX0: step.controlWord = 12'h823;
            CAR_PUSH_IDX1: step.controlWord = 12'h230;
            CAR_PUSH_IDX2: step.controlWord = 12'h324;
            CAR_PUSH_IDX3: step.controlWord = 12'h400;
            CAR_CALL_REG0: step.controlWord = 12'h010;
            CAR_CALL_REG1: step.controlWord = 12'h304;
            CAR_CALL_REG2: step.controlWord = 12'h120;
            CAR_CALL_IND0: step.controlWord = 12'h23C;
            CAR_CALL_IND1: step.controlWord = 12'h304;
            CAR_CALL_IND2: step.controlWord = 12'h120;
            CAR_CALL_IDX0: step.controlWord = 12'h803;
            CAR_CALL_IDX1: step.controlWord = 12'h230;
            CAR_CALL_IDX2: step.controlWord = 12'h304;
            CAR_CALL_IDX3: step.controlWord = 12'h120;
            CAR_RETI0:     step.controlWord = 12'h2C8;
            CAR_RETI1:     step.controlWord = 12'h180;
            CAR_RETI2:     step.controlWord = 12'h2C8;
            CAR_RETI3:     step.controlWord = 12'h180;
            CAR_INT0:      step.controlWord = 12'h010;
            CAR_INT1:      step.controlWord = 12'h324;
            CAR_INT2:      step.controlWord = 12'h010;
            CAR_INT3:      step.controlWord = 12'h324;
            CAR_JMP0:      step.controlWord = 12'h100;
            default:       step.controlWord = 12'h000;   // idle and INT4.
        endcase

        // stack based states work through SP.
        case (car)
            CAR_PUSH_REG0, CAR_PUSH_REG1, CAR_PUSH_REG2,
            CAR_PUSH_IND0, CAR_PUSH_IND1, CAR_PUSH_IND2,
            CAR_PUSH_IDX0, CAR_PUSH_IDX1, CAR_PUSH_IDX2, CAR_PUSH_IDX3,
            CAR_CALL_REG0, CAR_CALL_REG1, CAR_CALL_REG2,
            CAR_CALL_IND0, CAR_CALL_IND1, CAR_CALL_IND2,
            CAR_CALL_IDX0, CAR_CALL_IDX1, CAR_CALL_IDX2, CAR_CALL_IDX3,
            CAR_RETI0, CAR_RETI2, CAR_INT0, CAR_INT1, CAR_INT2, CAR_INT3:
                step.srcA = SP;
            default: ;
        endcase

        case (car)
            CAR_CALL_REG1, CAR_CALL_REG2, CAR_CALL_IND1, CAR_CALL_IND2,
            CAR_CALL_IDX2, CAR_CALL_IDX3, CAR_RETI2, CAR_RETI3,
            CAR_INT0, CAR_INT1, CAR_JMP0:
                step.dstA = PC;
            CAR_RETI0, CAR_RETI1, CAR_INT2, CAR_INT3:
                step.dstA = SR;
            default: ;
        endcase

        if (car == CAR_RETI0 || car == CAR_RETI2) step.as = 2'b11;   // pop with autoincrement.
    end

    // an idle controller must not disturb the datapath.
    always_comb begin
        if (car == CAR_IDLE) begin
            idleIsQuiet: assert (step.controlWord == '0 && !intAck)
                else $error("active control output while CAR is idle");
        end
    end

endmodule

// File: dv/ctrlStepTable.svh
// expected microstep table: row stimulus and per-step CAR, control word and operand fields.
`ifndef ctrlStepTableSvh
`define ctrlStepTableSvh

// rows: instruction, bits replaced from $random, intReq, stall, step count.
typedef struct packed {
    logic [15:0] instr;
    logic [15:0] mask;
    logic        intReq;
    logic        stall;     // run into a full trace FIFO.
    logic [7:0]  count;
} rowSpec;

localparam int NumRows     = 12;
localparam int NumSteps    = 41;
localparam int IndIdxFirst = 16;    // first step of the IND_IDX row.

localparam rowSpec rows [NumRows] = '{
    '{16'h4000, 16'h0F0F, 1'b0, 1'b0, 8'd1},    // REG_REG.
    '{16'h4080, 16'h0F0F, 1'b0, 1'b0, 8'd4},    // REG_IDX.
    '{16'h4010, 16'h0F0F, 1'b0, 1'b0, 8'd3},    // IDX_REG.
    '{16'h4090, 16'h0F0F, 1'b0, 1'b1, 8'd6},    // IDX_IDX against back-pressure.
    '{16'h4020, 16'h0F0F, 1'b0, 1'b0, 8'd2},    // IND_REG.
    '{16'h40B0, 16'h0F0F, 1'b0, 1'b0, 8'd5},    // IND_IDX.
    '{16'h1020, 16'h000F, 1'b0, 1'b0, 8'd3},    // rrc @rn.
    '{16'h1200, 16'h000F, 1'b0, 1'b0, 8'd3},    // push rn.
    '{16'h1290, 16'h000F, 1'b0, 1'b0, 8'd4},    // call x(rn).
    '{16'h1300, 16'h0000, 1'b0, 1'b0, 8'd4},    // reti.
    '{16'h3C00, 16'h03FF, 1'b0, 1'b0, 8'd1},    // jmp.
    '{16'h0000, 16'h0000, 1'b1, 1'b0, 8'd5}     // interrupt entry.
};

// steps: {car[7:0], controlWord, srcA, dstA, As}, an F nibble takes the instruction's field.
localparam logic [31:0] stepTable [NumSteps] = '{
    32'h01_500_FFF,
    32'h02_823_FFF, 32'h03_230_FFF, 32'h04_320_FFF, 32'h05_400_FFF,
    32'h0D_882_FFF, 32'h0E_2C0_FFF, 32'h0F_580_FFF,
    32'h10_8A2_FFF, 32'h11_2E0_FFF, 32'h12_8A3_FFF,
    32'h13_2B0_FFF, 32'h14_3A0_FFF, 32'h15_400_FFF,
    32'h06_2C8_FFF, 32'h07_580_FFF,
    32'h08_2E8_FFF, 32'h09_8A3_FFF, 32'h0A_2B0_FFF, 32'h0B_3A0_FFF, 32'h0C_400_FFF,
    32'h17_23E_FFF, 32'h18_320_FFF, 32'h19_420_FFF,
    32'h1E_010_1FF, 32'h1F_324_1FF, 32'h20_400_1FF,
    32'h2E_803_1FF, 32'h2F_230_1FF, 32'h30_304_10F, 32'h31_120_10F,
    32'h32_2C8_123, 32'h33_180_F2F, 32'h34_2C8_103, 32'h35_180_F0F,
    32'h3B_100_F0F,
    32'h36_010_10F, 32'h37_324_10F, 32'h38_010_12F, 32'h39_324_12F, 32'h3A_000_FFF
};

`endif

// File: dv/msp430ControlTb.sv
// testbench: clock, reset, APB tasks, step table loop, trace checks, error responses, watchdog.
module msp430ControlTb;
    timeunit 1ns;
    timeprecision 100ps;

    `include "ctrlStepTable.svh"

    localparam int          ClkPeriod   = 20;
    localparam int          ResetCycles = 10;
    localparam int          TraceDepth  = 5;     // one short of the longest sequence.
    localparam logic [3:0]  IrAddr      = 4'h0;
    localparam logic [3:0]  StatusAddr  = 4'h4;
    localparam logic [3:0]  TraceAddr   = 4'h8;
    localparam logic [15:0] PushWord    = 16'h1200;
    localparam logic [7:0]  Int1Car     = 8'h37;
    localparam logic [7:0]  Int3Car     = 8'h39;

    logic        clk = 1'b0;
    logic        rstN;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        intReq;
    logic        intAck;
    int          checks = 0;
    int          errors = 0;
    int          ackCount = 0;
    time         ackTime = 0;        // last falling edge with intAck high.
    integer      seed = 32'h732a;
    logic [15:0] lastIr;             // word held by the sequencer.

    msp430Control #(.TraceDepth(TraceDepth), .AddrBits(4)) UUT (
        .clk, .rstN, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
        .intReq, .intAck
    );

    always #(ClkPeriod / 2) clk = ~clk;

    always @(negedge clk) begin
        if (intAck === 1'b1) begin
            ackCount++;                      // cycles with intAck high.
            ackTime = $time;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual,
                     expected);
        end
    endtask

    // ##########################################################################
    // APB master, inputs change on the falling edge.
    // ##########################################################################
    task automatic busTransfer(input logic write, input logic [3:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #(ClkPeriod / 4);                    // mid access phase.
        rdata = prdata;
        err   = pslverr;
        checkValue("pready", 32'(pready), 32'd1);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apbWrite(input logic [3:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] unused;
        busTransfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apbRead(input logic [3:0] addr, output logic [31:0] data, output logic err);
        busTransfer(1'b0, addr, 32'd0, data, err);
    endtask

    task automatic waitIdle(output logic [31:0] status);
        logic err;
        do begin
            apbRead(StatusAddr, status, err);
        end while (status[0]);
    endtask

    // one trace entry against one table step.
    task automatic checkStep(input logic [31:0] exp, input logic [31:0] data,
                             input logic [15:0] ir);
        logic [15:0] w;
        logic [3:0]  src;
        logic [3:0]  dst;
        logic [1:0]  as;
        w   = (exp[31:24] == Int1Car || exp[31:24] == Int3Car) ? PushWord : ir;
        src = (exp[11:8] == 4'hF) ? w[11:8] : exp[11:8];
        dst = (exp[7:4] == 4'hF) ? w[3:0] : exp[7:4];
        as  = (exp[3:0] == 4'hF) ? w[5:4] : exp[1:0];
        checkValue("car", 32'(data[29:24]), 32'(exp[31:24]));
        checkValue("controlWord", 32'(data[23:12]), 32'(exp[23:12]));
        checkValue("srcA", 32'(data[11:8]), 32'(src));
        checkValue("dstA", 32'(data[7:4]), 32'(dst));
        checkValue("As", 32'(data[3:2]), 32'(as));
        checkValue("Ad", 32'(data[1]), 32'(w[7]));
        checkValue("format", 32'(data[0]), 32'(w[15:10] == 6'b000100));
        checkValue("trace pad", 32'(data[31:30]), 32'd0);
    endtask

    task automatic drainTrace(input int first, input int n, input logic [15:0] ir);
        logic [31:0] data;
        logic        err;
        for (int k = 0; k < n; k++) begin
            apbRead(TraceAddr, data, err);
            checkValue("pslverr", 32'(err), 32'd0);
            checkStep(stepTable[first + k], data, ir);
        end
        apbRead(StatusAddr, data, err);
        checkValue("trace count", 32'(data[15:8]), 32'd0);
    endtask

    task automatic runRow(input rowSpec row, input int first);
        logic [31:0] status;
        logic        err;
        logic [15:0] word;
        int          acksBefore;
        time         reqTime;
        word       = (row.instr & ~row.mask) | (16'($random(seed)) & row.mask);
        acksBefore = ackCount;
        reqTime    = 0;
        if (row.intReq) begin
            @(negedge clk);
            intReq  = 1'b1;                  // taken while idle.
            reqTime = $time;
            @(negedge clk);
            intReq = 1'b0;
        end else begin
            apbWrite(IrAddr, {16'd0, word}, err);
            checkValue("pslverr", 32'(err), 32'd0);
            lastIr = word;
        end
        if (row.stall) begin
            // no reads until the sequence should long be over.
            repeat (int'(row.count) + 4) @(negedge clk);
            apbRead(StatusAddr, status, err);
            checkValue("busy", 32'(status[0]), 32'd1);
            checkValue("full", 32'(status[1]), 32'd1);
            checkValue("trace count", 32'(status[15:8]), 32'(TraceDepth));
        end else begin
            waitIdle(status);
        end
        drainTrace(first, int'(row.count), lastIr);
        checkValue("intAck cycles", 32'(ackCount - acksBefore), 32'(row.intReq));
        if (row.intReq) begin
            // INT0 on the next edge, INT4 four cycles on.
            checkValue("intAck delay", 32'(ackTime - reqTime), 32'(5 * ClkPeriod));
        end
    endtask

    task automatic errorResponses();
        logic [31:0] data;
        logic        err;
        apbRead(TraceAddr, data, err);       // empty FIFO.
        checkValue("pslverr", 32'(err), 32'd1);
        checkValue("prdata", data, 32'd0);
        apbWrite(IrAddr, 32'h0000_40B0, err);
        checkValue("pslverr", 32'(err), 32'd0);
        lastIr = 16'h40B0;
        apbWrite(IrAddr, 32'h0000_4000, err);   // lands mid sequence.
        checkValue("pslverr", 32'(err), 32'd1);
        waitIdle(data);
        checkValue("trace count", 32'(data[15:8]), 32'(rows[5].count));
        drainTrace(IndIdxFirst, int'(rows[5].count), lastIr);
    endtask

    // ##########################################################################
    // main sequence and watchdog.
    // ##########################################################################
    initial begin
        int          first;
        logic [31:0] status;
        logic        err;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 4'h0;
        pwdata  = 32'd0;
        intReq  = 1'b0;
        rstN    = 1'b0;
        lastIr  = 16'd0;
        first   = 0;
        repeat (ResetCycles) @(negedge clk);
        rstN = 1'b1;
        checkValue("intAck", 32'(intAck), 32'd0);
        apbRead(StatusAddr, status, err);
        checkValue("status after reset", status, 32'd0);
        for (int r = 0; r < NumRows; r++) begin
            runRow(rows[r], first);
            first += int'(rows[r].count);
        end
        errorResponses();
        $display("%0d checks, %0d mismatches", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #((NumRows * 40 + ResetCycles) * ClkPeriod);
        $display("Timeout: the run did not finish within %0d cycles", NumRows * 40 + ResetCycles);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: msp430Control.f
+incdir+dv
common/msp430CtrlPkg.sv
controller/carSequencer.sv
controller/controlUnit.sv
verilog/stepRecorder.sv
verilog/apbCtrlPort.sv
verilog/msp430Control.sv
dv/msp430ControlTb.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the msp430Control testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f msp430Control.f \
    --top-module msp430ControlTb -o msp430ControlSim
if [ $? -ne 0 ]; then
    echo "error: verilator compile failed"
    exit 1
fi

output=$(./obj_dir/msp430ControlSim)
simStatus=$?
echo "$output"
if [ $simStatus -ne 0 ]; then
    echo "error: simulation exited with status $simStatus"
    exit 1
fi

if echo "$output" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
echo "error: pass message not found in simulation output"
exit 1

// File: verilog/apbCtrlPort.sv
// apbCtrlPort: APB slave with instruction write, status read and popping trace read.
module apbCtrlPort #(
    parameter int AddrBits = 4
) (
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [AddrBits-1:0]      paddr,
    input  logic [31:0]              pwdata,
    output logic [31:0]              prdata,
    output logic                     pready,
    output logic                     pslverr,
    output msp430CtrlPkg::instrWord  irWord,
    output logic                     start,
    input  logic                     busy,
    input  msp430CtrlPkg::traceEntry traceHead,
    input  logic [7:0]               count,
    input  logic                     full,
    output logic                     pop
);
    import msp430CtrlPkg::*;

    logic      access;
    logic      wrIr;
    logic      rdStatus;
    logic      rdTrace;
    logic      traceEmpty;
    statusWord status;

    // #########################################################################
    // address decode, access phase only.
    // #########################################################################
    assign access     = psel && penable;
    assign wrIr       = access && pwrite && (paddr == AddrBits'(AddrIr));
    assign rdStatus   = access && !pwrite && (paddr == AddrBits'(AddrStatus));
    assign rdTrace    = access && !pwrite && (paddr == AddrBits'(AddrTrace));
    assign traceEmpty = (count == 8'd0);

    assign pready = 1'b1;                  // no wait states.
    assign irWord = pwdata[15:0];
    assign start  = wrIr && !busy;
    assign pop    = rdTrace && !traceEmpty;

    // late instruction writes and empty trace reads.
    assign pslverr = (wrIr && busy) || (rdTrace && traceEmpty);

    always_comb begin
        status          = '0;
        status.count    = count;
        status.full     = full;
        status.busy     = busy;
    end

    always_comb begin
        prdata = 32'd0;
        if (rdStatus) prdata = status;
        else if (pop) prdata = traceHead;   // zero when empty.
    end

endmodule

// File: verilog/msp430Control.sv
// msp430Control: top level joining the APB port, CAR sequencer, control unit and trace recorder.
module msp430Control #(
    parameter int TraceDepth = 16,
    parameter int AddrBits   = 4
) (
    input  logic                clk,
    input  logic                rstN,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [AddrBits-1:0] paddr,
    input  logic [31:0]         pwdata,
    output logic [31:0]         prdata,
    output logic                pready,
    output logic                pslverr,
    input  logic                intReq,
    output logic                intAck
);
    import msp430CtrlPkg::*;

    instrWord  irWord;
    instrWord  ir;
    carState   car;
    ctrlStep   step;
    traceEntry traceHead;
    logic      start;
    logic      busy;
    logic      stepValid;
    logic      pop;
    logic      full;
    logic [7:0] count;

    apbCtrlPort #(.AddrBits(AddrBits)) port (
        .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
        .irWord, .start, .busy, .traceHead, .count, .full, .pop
    );

    carSequencer sequencer (
        .clk, .rstN, .start, .irWord, .intReq, .full, .car, .ir, .stepValid, .busy
    );

    controlUnit control (.car, .ir, .step, .intAck);

    stepRecorder #(.TraceDepth(TraceDepth)) recorder (
        .clk, .rstN, .push(stepValid), .step, .pop, .traceHead, .count, .full
    );

endmodule

// File: verilog/stepRecorder.sv
// stepRecorder: circular trace FIFO of executed microsteps with count, full flag and pop.
module stepRecorder #(
    parameter int TraceDepth = 16      // 2 to 255 entries.
) (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     push,
    input  msp430CtrlPkg::ctrlStep   step,
    input  logic                     pop,
    output msp430CtrlPkg::traceEntry traceHead,
    output logic [7:0]               count,
    output logic                     full
);
    import msp430CtrlPkg::*;

    localparam int PtrBits = $clog2(TraceDepth);

    ctrlStep              mem [TraceDepth];
    logic [PtrBits-1:0]   wrPtr;
    logic [PtrBits-1:0]   rdPtr;
    logic                 doPush;
    logic                 doPop;

    function automatic logic [PtrBits-1:0] bump(logic [PtrBits-1:0] ptr);
        return (ptr == PtrBits'(TraceDepth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign doPush = push && !full;
    assign doPop  = pop && (count != 8'd0);

    always_ff @(posedge clk) begin
        if (doPush) mem[wrPtr] <= step;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= 8'd0;
        end else begin
            if (doPush) wrPtr <= bump(wrPtr);
            if (doPop) rdPtr <= bump(rdPtr);
            case ({doPush, doPop})
                2'b10:   count <= count + 8'd1;
                2'b01:   count <= count - 8'd1;
                default: count <= count;        // both or neither.
            endcase
        end
    end

    assign full = (count == 8'(TraceDepth));

    always_comb begin
        traceHead.pad  = '0;
        traceHead.step = mem[rdPtr];
    end

    // the sequencer stalls before the FIFO overflows.
    noPushWhenFull: assert property (@(posedge clk) disable iff (!rstN) !(push && full));

endmodule
